/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sources.f --top-module csr_unit_tb -o csr_unit_sim

out=$(./obj_dir/csr_unit_sim) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_alu.sv
verilog/trap_ctrl.sv
verilog/csr_file.sv
verilog/csr_unit.sv
tests/csr_unit_asserts.sv
tests/csr_unit_tb.sv

/* tests/csr_unit_asserts.sv */
`timescale 1ns/1ns

module csr_unit_asserts (
    input logic clk,
    input logic rst,
    input logic csr_en,
    input logic ecall,
    input logic mret,
    input logic redirect,
    input logic illegal
);

    // At most one request per cycle.
    one_request: assert property (@(posedge clk) disable iff (rst)
        $onehot0({csr_en, ecall, mret}))
        else $error("csr_en, ecall and mret were active together");

    redirect_on_trap: assert property (@(posedge clk) disable iff (rst)
        redirect == (ecall | mret))
        else $error("redirect does not follow ecall or mret");

    illegal_needs_en: assert property (@(posedge clk) disable iff (rst)
        illegal |-> csr_en)
        else $error("illegal raised without csr_en");

endmodule

bind csr_unit csr_unit_asserts asserts_inst (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .ecall    (ecall),
    .mret     (mret),
    .redirect (redirect),
    .illegal  (illegal)
);

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ns
`include "csr_consts.svh"

module csr_unit_tb;
    import csr_pkg::*;
    import trap_pkg::*;

    logic        clk;
    logic        rst;
    logic        csr_en;
    csr_funct3_t csr_funct3;
    csr_addr_t   csr_addr;
    csr_word_t   rs1_data;
    logic [4:0]  rs1_idx;
    logic        ecall;
    logic        mret;
    pc_t         pc;
    csr_word_t   rd_data;
    logic        illegal;
    logic        redirect;
    pc_t         redirect_pc;

    // Reference copy of the CSRs.
    csr_word_t   m_mstatus;
    csr_word_t   m_mtvec;
    pc_t         m_mepc;
    cause_t      m_mcause;

    logic [31:0] seed;
    int          errors;
    int          checks;

    csr_unit csr_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .csr_en      (csr_en),
        .csr_funct3  (csr_funct3),
        .csr_addr    (csr_addr),
        .rs1_data    (rs1_data),
        .rs1_idx     (rs1_idx),
        .ecall       (ecall),
        .mret        (mret),
        .pc          (pc),
        .rd_data     (rd_data),
        .illegal     (illegal),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    function automatic logic is_known(input csr_addr_t addr);
        return addr == `CSR_MSTATUS || addr == `CSR_MTVEC ||
               addr == `CSR_MEPC || addr == `CSR_MCAUSE;
    endfunction

    function automatic csr_word_t model_read(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            default:      return '0;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Drives one cycle, checks the outputs before the edge and updates the model.
    // ------------------------------------------------------------------
    task automatic run_cycle(input string name, input logic en, input csr_funct3_t f3,
                             input csr_addr_t addr, input csr_word_t rs1,
                             input logic [4:0] idx, input logic ec, input logic mr,
                             input pc_t pc_v);
        csr_word_t old_v;
        csr_word_t opnd;
        csr_word_t new_v;
        logic      imm;
        logic      set_clr;
        logic      writes;
        pc_t       exp_pc;

        @(negedge clk);
        csr_en     = en;
        csr_funct3 = f3;
        csr_addr   = addr;
        rs1_data   = rs1;
        rs1_idx    = idx;
        ecall      = ec;
        mret       = mr;
        pc         = pc_v;

        old_v   = en ? model_read(addr) : '0;
        imm     = (f3 == `F3_CSRRWI || f3 == `F3_CSRRSI || f3 == `F3_CSRRCI);
        set_clr = !(f3 == `F3_CSRRW || f3 == `F3_CSRRWI);
        opnd    = imm ? {27'd0, idx} : rs1;
        case (f3)
            `F3_CSRRW, `F3_CSRRWI: new_v = opnd;
            `F3_CSRRS, `F3_CSRRSI: new_v = model_read(addr) | opnd;
            default:               new_v = model_read(addr) & ~opnd;
        endcase
        writes = en && is_known(addr) && !(set_clr && idx == 5'd0);
        exp_pc = ec ? {m_mtvec[31:2], 2'b00} : (mr ? m_mepc : '0);

        #5;
        check_value({name, " rd_data"}, old_v, rd_data);
        check_value({name, " illegal"}, {31'd0, en && !is_known(addr)}, {31'd0, illegal});
        check_value({name, " redirect"}, {31'd0, ec || mr}, {31'd0, redirect});
        check_value({name, " redirect_pc"}, exp_pc, redirect_pc);

        if (writes) begin
            case (addr)
                `CSR_MSTATUS: m_mstatus = new_v;
                `CSR_MTVEC:   m_mtvec   = new_v;
                `CSR_MEPC:    m_mepc    = {new_v[31:2], 2'b00};  // Low bits read zero.
                `CSR_MCAUSE:  m_mcause  = new_v;
                default:      ;
            endcase
        end
        if (ec) begin
            m_mepc   = {pc_v[31:2], 2'b00};
            m_mcause = `CAUSE_ECALL_M;
            m_mstatus[`MSTATUS_MPIE_BIT]     = m_mstatus[`MSTATUS_MIE_BIT];
            m_mstatus[`MSTATUS_MIE_BIT]      = 1'b0;
            m_mstatus[`MSTATUS_MPP_LSB +: 2] = 2'b11;
        end else if (mr) begin
            m_mstatus[`MSTATUS_MIE_BIT]      = m_mstatus[`MSTATUS_MPIE_BIT];
            m_mstatus[`MSTATUS_MPIE_BIT]     = 1'b1;
            m_mstatus[`MSTATUS_MPP_LSB +: 2] = 2'b00;
        end
    endtask

    // csrrs with x0 never writes.
    task automatic read_csr(input string name, input csr_addr_t addr);
        run_cycle(name, 1'b1, `F3_CSRRS, addr, '0, 5'd0, 1'b0, 1'b0, '0);
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        csr_addr_t   addr_pool [8];
        csr_funct3_t f3_pool [8];
        logic [4:0]  idx;

        addr_pool = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE,
                      `CSR_MSTATUS, `CSR_MEPC, 12'h301, 12'h7c0};
        f3_pool   = '{`F3_CSRRW, `F3_CSRRS, `F3_CSRRC, `F3_CSRRWI,
                      `F3_CSRRSI, `F3_CSRRCI, `F3_CSRRS, `F3_CSRRCI};
        r   = next_rand();
        idx = (r[29:28] == 2'd0) ? 5'd0 : r[12:8];  // Favor x0 and zimm 0.
        if (r[27:24] < 4'd10) begin
            run_cycle("csr", 1'b1, f3_pool[r[22:20]], addr_pool[r[18:16]],
                      next_rand(), idx, 1'b0, 1'b0, next_rand());
        end else if (r[27:24] < 4'd12) begin
            run_cycle("ecall", 1'b0, f3_pool[r[22:20]], addr_pool[r[18:16]],
                      next_rand(), idx, 1'b1, 1'b0, next_rand());
        end else if (r[27:24] < 4'd14) begin
            run_cycle("mret", 1'b0, f3_pool[r[22:20]], addr_pool[r[18:16]],
                      next_rand(), idx, 1'b0, 1'b1, next_rand());
        end else begin
            run_cycle("idle", 1'b0, f3_pool[r[22:20]], addr_pool[r[18:16]],
                      next_rand(), idx, 1'b0, 1'b0, next_rand());
        end
    endtask

    task automatic wait_quiet();
        int n;

        n = 0;
        @(negedge clk);
        csr_en = 1'b0;
        ecall  = 1'b0;
        mret   = 1'b0;
        #5;
        while ((redirect || illegal) && n < 20) begin
            @(negedge clk);
            #5;
            n++;
        end
        if (redirect || illegal) begin
            errors++;
            $display("Timeout: redirect or illegal still high after the inputs went idle");
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------------
    initial begin
        int i;

        seed       = 32'd49950;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        csr_en     = 1'b0;
        csr_funct3 = '0;
        csr_addr   = '0;
        rs1_data   = '0;
        rs1_idx    = '0;
        ecall      = 1'b0;
        mret       = 1'b0;
        pc         = '0;
        m_mstatus  = `MSTATUS_RESET;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = `MCAUSE_RESET;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_csr("reset mstatus", `CSR_MSTATUS);
        read_csr("reset mtvec", `CSR_MTVEC);
        read_csr("reset mepc", `CSR_MEPC);
        read_csr("reset mcause", `CSR_MCAUSE);

        // Trap entry and return with MIE set.
        run_cycle("mtvec write", 1'b1, `F3_CSRRW, `CSR_MTVEC, 32'h0000_0103, 5'd1,
                  1'b0, 1'b0, '0);
        run_cycle("mie set", 1'b1, `F3_CSRRSI, `CSR_MSTATUS, '0, 5'd8, 1'b0, 1'b0, '0);
        run_cycle("ecall", 1'b0, `F3_CSRRW, '0, '0, 5'd0, 1'b1, 1'b0, 32'h0000_2046);
        read_csr("ecall mepc", `CSR_MEPC);
        read_csr("ecall mcause", `CSR_MCAUSE);
        read_csr("ecall mstatus", `CSR_MSTATUS);
        run_cycle("mret", 1'b0, `F3_CSRRW, '0, '0, 5'd0, 1'b0, 1'b1, '0);
        read_csr("mret mstatus", `CSR_MSTATUS);

        for (i = 0; i < 2000; i++) begin
            random_cycle();
        end
        wait_quiet();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog/csr_alu.sv */
`timescale 1ns/1ns
`include "csr_consts.svh"

module csr_alu (
    input  logic                 csr_en,
    input  csr_pkg::csr_funct3_t csr_funct3,
    input  csr_pkg::csr_word_t   rs1_data,
    input  logic [4:0]           rs1_idx,
    input  csr_pkg::csr_word_t   old_data,
    output logic                 alu_we,
    output csr_pkg::csr_word_t   alu_wdata
);
    import csr_pkg::*;

    csr_word_t operand;
    logic      imm_form;
    logic      valid_op;
    logic      read_only;

    assign imm_form = csr_funct3[2];  // Immediate forms.
    assign operand  = imm_form ? {27'd0, rs1_idx} : rs1_data;

    // ----------------------------------------------------------------------
    // New value.
    // ----------------------------------------------------------------------
    always_comb begin
        case (csr_funct3)
            `F3_CSRRW, `F3_CSRRWI: alu_wdata = operand;
            `F3_CSRRS, `F3_CSRRSI: alu_wdata = old_data | operand;
            `F3_CSRRC, `F3_CSRRCI: alu_wdata = old_data & ~operand;
            default:               alu_wdata = old_data;
        endcase
    end

    // Codes 0 and 4 are not Zicsr.
    assign valid_op = (csr_funct3[1:0] != 2'b00);

    // Set or clear with x0 or zimm 0 reads only.
    assign read_only = csr_funct3[1] && (rs1_idx == 5'd0);

    assign alu_we = csr_en && valid_op && !read_only;

endmodule

/* verilog/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// ----------------------------------------------------------------------
// Machine-mode CSR addresses.
// ----------------------------------------------------------------------
`define CSR_MSTATUS      12'h300
`define CSR_MTVEC        12'h305
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342

// Zicsr funct3 codes.
`define F3_CSRRW         3'd1
`define F3_CSRRS         3'd2
`define F3_CSRRC         3'd3
`define F3_CSRRWI        3'd5
`define F3_CSRRSI        3'd6
`define F3_CSRRCI        3'd7

`define MSTATUS_RESET    32'h0000_1800  // MPP = M-mode.
`define MCAUSE_RESET     32'h0000_000b
`define CAUSE_ECALL_M    32'd11

`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LSB  11             // Two bits wide.

`endif

/* verilog/csr_file.sv */
`timescale 1ns/1ns
`include "csr_consts.svh"

module csr_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_en,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               alu_we,
    input  csr_pkg::csr_word_t alu_wdata,
    input  logic               trap_we,
    input  csr_pkg::csr_word_t mstatus_next,
    input  logic               epc_we,
    input  trap_pkg::pc_t      epc,
    input  trap_pkg::cause_t   cause,
    input  logic               redirect_ecall,
    input  logic               redirect_mret,
    output csr_pkg::csr_word_t old_data,
    output csr_pkg::csr_word_t mstatus_q,
    output csr_pkg::csr_word_t rd_data,
    output logic               illegal,
    output logic               redirect,
    output trap_pkg::pc_t      redirect_pc
);
    import csr_pkg::*;
    import trap_pkg::*;

    csr_word_t mtvec_q;
    pc_t       mepc_q;
    cause_t    mcause_q;

    logic sel_mstatus;
    logic sel_mtvec;
    logic sel_mepc;
    logic sel_mcause;
    logic addr_hit;

    // ----------------------------------------------------------------------
    // Address decode.
    // ----------------------------------------------------------------------
    assign sel_mstatus = (csr_addr == `CSR_MSTATUS);
    assign sel_mtvec   = (csr_addr == `CSR_MTVEC);
    assign sel_mepc    = (csr_addr == `CSR_MEPC);
    assign sel_mcause  = (csr_addr == `CSR_MCAUSE);
    assign addr_hit    = sel_mstatus | sel_mtvec | sel_mepc | sel_mcause;

    // ----------------------------------------------------------------------
    // Registers.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= `MSTATUS_RESET;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= `MCAUSE_RESET;
        end else begin
            if (trap_we) begin
                mstatus_q <= mstatus_next;
            end else if (alu_we && sel_mstatus) begin
                mstatus_q <= alu_wdata;
            end
            if (alu_we && sel_mtvec) begin
                mtvec_q <= alu_wdata;
            end
            if (epc_we) begin
                mepc_q   <= epc;
                mcause_q <= cause;
            end else begin
                if (alu_we && sel_mepc) begin
                    mepc_q <= {alu_wdata[31:2], 2'b00};  // Low bits hardwired.
                end
                if (alu_we && sel_mcause) begin
                    mcause_q <= alu_wdata;
                end
            end
        end
    end

    // Unknown addresses read zero.
    always_comb begin
        old_data = '0;
        if (sel_mstatus) old_data = mstatus_q;
        if (sel_mtvec)   old_data = mtvec_q;
        if (sel_mepc)    old_data = mepc_q;
        if (sel_mcause)  old_data = mcause_q;
    end

    assign rd_data = csr_en ? old_data : '0;
    assign illegal = csr_en & ~addr_hit;

    assign redirect    = redirect_ecall | redirect_mret;
    assign redirect_pc = redirect_ecall ? {mtvec_q[31:2], 2'b00} :  // Direct mode only.
                         redirect_mret  ? mepc_q : '0;

endmodule

/* verilog/csr_pkg.sv */
package csr_pkg;

    // CSR data word and rs1 operand.
    typedef logic [31:0] csr_word_t;

    typedef logic [11:0] csr_addr_t;

    // Selects the Zicsr operation.
    typedef logic [2:0]  csr_funct3_t;

endpackage

/* verilog/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 csr_en,
    input  csr_pkg::csr_funct3_t csr_funct3,
    input  csr_pkg::csr_addr_t   csr_addr,
    input  csr_pkg::csr_word_t   rs1_data,
    input  logic [4:0]           rs1_idx,
    input  logic                 ecall,
    input  logic                 mret,
    input  trap_pkg::pc_t        pc,
    output csr_pkg::csr_word_t   rd_data,
    output logic                 illegal,
    output logic                 redirect,
    output trap_pkg::pc_t        redirect_pc
);
    import csr_pkg::*;
    import trap_pkg::*;

    // CSR instruction path.
    csr_word_t old_data;
    csr_word_t alu_wdata;
    logic      alu_we;

    // Trap path.
    csr_word_t mstatus_q;
    csr_word_t mstatus_next;
    logic      trap_we;
    logic      epc_we;
    pc_t       epc;
    cause_t    cause;
    logic      redirect_ecall;
    logic      redirect_mret;

    csr_alu alu_inst (
        .csr_en     (csr_en),
        .csr_funct3 (csr_funct3),
        .rs1_data   (rs1_data),
        .rs1_idx    (rs1_idx),
        .old_data   (old_data),
        .alu_we     (alu_we),
        .alu_wdata  (alu_wdata)
    );

    trap_ctrl trap_inst (
        .ecall          (ecall),
        .mret           (mret),
        .pc             (pc),
        .mstatus_q      (mstatus_q),
        .trap_we        (trap_we),
        .epc_we         (epc_we),
        .mstatus_next   (mstatus_next),
        .epc            (epc),
        .cause          (cause),
        .redirect_ecall (redirect_ecall),
        .redirect_mret  (redirect_mret)
    );

    csr_file file_inst (
        .clk            (clk),
        .rst            (rst),
        .csr_en         (csr_en),
        .csr_addr       (csr_addr),
        .alu_we         (alu_we),
        .alu_wdata      (alu_wdata),
        .trap_we        (trap_we),
        .mstatus_next   (mstatus_next),
        .epc_we         (epc_we),
        .epc            (epc),
        .cause          (cause),
        .redirect_ecall (redirect_ecall),
        .redirect_mret  (redirect_mret),
        .old_data       (old_data),
        .mstatus_q      (mstatus_q),
        .rd_data        (rd_data),
        .illegal        (illegal),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* verilog/trap_ctrl.sv */
`timescale 1ns/1ns
`include "csr_consts.svh"

module trap_ctrl (
    input  logic               ecall,
    input  logic               mret,
    input  trap_pkg::pc_t      pc,
    input  csr_pkg::csr_word_t mstatus_q,
    output logic               trap_we,
    output logic               epc_we,
    output csr_pkg::csr_word_t mstatus_next,
    output trap_pkg::pc_t      epc,
    output trap_pkg::cause_t   cause,
    output logic               redirect_ecall,
    output logic               redirect_mret
);
    import csr_pkg::*;
    import trap_pkg::*;

    csr_word_t mstatus_ecall;
    csr_word_t mstatus_mret;

    // Trap entry stacks MIE into MPIE.
    always_comb begin
        mstatus_ecall                             = mstatus_q;
        mstatus_ecall[`MSTATUS_MPIE_BIT]          = mstatus_q[`MSTATUS_MIE_BIT];
        mstatus_ecall[`MSTATUS_MIE_BIT]           = 1'b0;
        mstatus_ecall[`MSTATUS_MPP_LSB +: 2]      = 2'b11;
    end

    // Return pops MPIE back.
    always_comb begin
        mstatus_mret                              = mstatus_q;
        mstatus_mret[`MSTATUS_MIE_BIT]            = mstatus_q[`MSTATUS_MPIE_BIT];
        mstatus_mret[`MSTATUS_MPIE_BIT]           = 1'b1;
        mstatus_mret[`MSTATUS_MPP_LSB +: 2]       = 2'b00;
    end

    assign mstatus_next = ecall ? mstatus_ecall : mstatus_mret;
    assign trap_we      = ecall | mret;

    assign epc_we = ecall;
    assign epc    = {pc[31:2], 2'b00};        // IALIGN is 32.
    assign cause  = cause_t'(`CAUSE_ECALL_M);

    assign redirect_ecall = ecall;
    assign redirect_mret  = mret & ~ecall;

endmodule

/* verilog/trap_pkg.sv */
package trap_pkg;

    // Program counter and trap target.
    typedef logic [31:0] pc_t;

    // Full mcause value.
    typedef logic [31:0] cause_t;

endpackage
